// File: exu_settings.svh
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// Operand and result width
`define EXU_DATA_W 32

// Register number width, r0 to r15
`define EXU_REG_W 4

// Input queue entries, also the credits upstream owns after reset
`define EXU_QUEUE_DEPTH 4

// Results in flight before a credit must come back
`define EXU_OUT_CREDITS 2

`endif

// File: exu_pkg.sv
`default_nettype none

`include "exu_settings.svh"

package exu_pkg;

  // Values follow instruction bits 24:21, the compare slot holds the no-op
  typedef enum logic [3:0] {
    alu_and = 4'h0,
    alu_eor = 4'h1,
    alu_sub = 4'h2,
    alu_rsb = 4'h3,
    alu_add = 4'h4,
    alu_adc = 4'h5,
    alu_sbc = 4'h6,
    alu_rsc = 4'h7,
    alu_nop = 4'h8,
    alu_orr = 4'hc,
    alu_mov = 4'hd,
    alu_bic = 4'he,
    alu_mvn = 4'hf
  } alu_op_e;

  typedef enum logic [3:0] {
    cond_eq, cond_ne, cond_cs, cond_cc,
    cond_mi, cond_pl, cond_vs, cond_vc,
    cond_hi, cond_ls, cond_ge, cond_lt,
    cond_gt, cond_le, cond_al, cond_nv
  } cond_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef struct packed {
    logic [31:0]            instr;
    logic [`EXU_DATA_W-1:0] rn_val;
    logic [`EXU_DATA_W-1:0] rm_val;
  } exu_req_t;

endpackage

`default_nettype wire

// File: exu_op_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "exu_settings.svh"

interface exu_op_if;
  import exu_pkg::*;

  logic                   valid;
  alu_op_e                alu_op;
  cond_e                  cond;
  logic                   set_flags;
  logic [`EXU_REG_W-1:0]  rd;
  logic [`EXU_DATA_W-1:0] operand_a;
  logic [`EXU_DATA_W-1:0] operand_b;
  logic                   take; // Execute consumes the held operation

  modport stage (output valid, alu_op, cond, set_flags, rd, operand_a, operand_b,
                 input take);

  modport exec (input valid, alu_op, cond, set_flags, rd, operand_a, operand_b,
                output take);

endinterface

`default_nettype wire

// File: exu_in_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "exu_settings.svh"

module exu_in_queue (
  input  logic              clk,
  input  logic              i_rst_n,
  input  logic              i_valid,
  input  exu_pkg::exu_req_t i_req,
  input  logic              i_pop,
  output exu_pkg::exu_req_t o_req,
  output logic              o_req_valid,
  output logic              o_credit_return
);
  import exu_pkg::*;

  localparam int DEPTH = `EXU_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  exu_req_t           mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               do_pop;

  // Upstream never writes into a full queue while it honors its credits
  assign do_pop      = i_pop && o_req_valid;
  assign o_req_valid = (count != '0);
  assign o_req       = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (i_valid) mem[wr_ptr] <= i_req;
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      count           <= '0;
      o_credit_return <= 1'b0;
    end else begin
      if (i_valid) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (i_valid && !do_pop) begin
        count <= count + 1'b1;
      end else if (!i_valid && do_pop) begin
        count <= count - 1'b1;
      end
      o_credit_return <= do_pop; // One credit back per popped entry
    end
  end

endmodule

`default_nettype wire

// File: exu_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "exu_settings.svh"

module exu_decode (
  input  logic              clk,
  input  logic              i_rst_n,
  input  exu_pkg::exu_req_t i_req,
  input  logic              i_req_valid,
  output logic              o_pop,
  exu_op_if.stage           op
);
  import exu_pkg::*;

  localparam int W = `EXU_DATA_W;

  logic [31:0]  instr;
  alu_op_e      dec_op;
  logic [W-1:0] dec_b;
  logic         load_en;

  function automatic logic [W-1:0] ror(input logic [W-1:0] val, input logic [4:0] amt);
    if (amt == '0) return val;
    return (val >> amt) | (val << (W - int'(amt)));
  endfunction

  // Amount zero leaves Rm untouched for every shift type
  function automatic logic [W-1:0] shift_imm(input logic [W-1:0] val,
                                             input logic [1:0]   kind,
                                             input logic [4:0]   amt);
    if (amt == '0) return val;
    case (kind)
      2'b00:   return val << amt;            // LSL
      2'b01:   return val >> amt;            // LSR
      2'b10:   return $signed(val) >>> amt;  // ASR
      default: return ror(val, amt);
    endcase
  endfunction

  assign instr = i_req.instr;

  always_comb begin
    dec_op = alu_nop;
    dec_b  = i_req.rm_val;
    // Data processing only, compares and the all-zero word fall to the no-op
    if (instr[27:26] == 2'b00 && instr[24:23] != 2'b10 && instr != '0) begin
      if (instr[25]) begin
        dec_op = alu_op_e'(instr[24:21]);
        dec_b  = ror(W'(instr[7:0]), {instr[11:8], 1'b0});
      end else if (!instr[4]) begin
        dec_op = alu_op_e'(instr[24:21]);
        dec_b  = shift_imm(i_req.rm_val, instr[6:5], instr[11:7]);
      end
    end
  end

  // Stage register refills when empty or when execute takes the current one
  assign load_en = !op.valid || op.take;
  assign o_pop   = i_req_valid && load_en;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      op.valid <= 1'b0;
    end else if (load_en) begin
      op.valid <= i_req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load_en) begin
      op.alu_op    <= dec_op;
      op.cond      <= cond_e'(instr[31:28]);
      op.set_flags <= instr[20] && (dec_op != alu_nop);
      op.rd        <= instr[15:12];
      op.operand_a <= i_req.rn_val;
      op.operand_b <= dec_b;
    end
  end

endmodule

`default_nettype wire

// File: exu_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "exu_settings.svh"

module exu_alu (
  input  exu_pkg::alu_op_e        i_op,
  input  logic [`EXU_DATA_W-1:0]  i_a,
  input  logic [`EXU_DATA_W-1:0]  i_b,
  input  logic                    i_carry,
  output logic [`EXU_DATA_W-1:0]  o_result,
  output exu_pkg::flags_t         o_flags
);
  import exu_pkg::*;

  localparam int W = `EXU_DATA_W;

  logic [W-1:0] add_x;
  logic [W-1:0] add_y;
  logic         add_cin;
  logic [W:0]   sum;
  logic         is_arith;
  logic         overflow;

  // All six arithmetic ops share one adder, subtraction as x + ~y + cin
  always_comb begin
    add_x   = i_a;
    add_y   = i_b;
    add_cin = 1'b0;
    case (i_op)
      alu_adc: add_cin = i_carry;
      alu_sub: begin
        add_y   = ~i_b;
        add_cin = 1'b1;
      end
      alu_sbc: begin
        add_y   = ~i_b;
        add_cin = i_carry;    // Borrow is the inverted carry
      end
      alu_rsb: begin
        add_x   = i_b;
        add_y   = ~i_a;
        add_cin = 1'b1;
      end
      alu_rsc: begin
        add_x   = i_b;
        add_y   = ~i_a;
        add_cin = i_carry;
      end
      default: ;
    endcase
  end

  assign sum      = {1'b0, add_x} + {1'b0, add_y} + {{W{1'b0}}, add_cin};
  assign is_arith = i_op inside {alu_add, alu_adc, alu_sub, alu_sbc, alu_rsb, alu_rsc};
  assign overflow = (add_x[W-1] == add_y[W-1]) && (sum[W-1] != add_x[W-1]);

  always_comb begin
    case (i_op)
      alu_and: o_result = i_a & i_b;
      alu_eor: o_result = i_a ^ i_b;
      alu_orr: o_result = i_a | i_b;
      alu_mov: o_result = i_b;
      alu_bic: o_result = i_a & ~i_b;
      alu_mvn: o_result = ~i_b;
      alu_nop: o_result = '0;
      default: o_result = sum[W-1:0];
    endcase
  end

  always_comb begin
    o_flags.n = o_result[W-1];
    o_flags.z = (o_result == '0);
    o_flags.c = is_arith && sum[W]; // Logic ops clear C and V
    o_flags.v = is_arith && overflow;
  end

endmodule

`default_nettype wire

// File: exu_psr_cond.sv
`timescale 1ns/1ns
`default_nettype none

module exu_psr_cond (
  input  logic             clk,
  input  logic             i_rst_n,
  input  exu_pkg::cond_e   i_cond,
  input  exu_pkg::flags_t  i_new_flags,
  input  logic             i_update,
  output exu_pkg::flags_t  o_flags,
  output logic             o_carry,
  output logic             o_cond_pass
);
  import exu_pkg::*;

  flags_t psr;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      psr <= '0;
    end else if (i_update) begin
      psr <= i_new_flags;
    end
  end

  assign o_flags = psr;
  assign o_carry = psr.c;

  always_comb begin
    case (i_cond)
      cond_eq: o_cond_pass = psr.z;
      cond_ne: o_cond_pass = !psr.z;
      cond_cs: o_cond_pass = psr.c;
      cond_cc: o_cond_pass = !psr.c;
      cond_mi: o_cond_pass = psr.n;
      cond_pl: o_cond_pass = !psr.n;
      cond_vs: o_cond_pass = psr.v;
      cond_vc: o_cond_pass = !psr.v;
      cond_hi: o_cond_pass = psr.c && !psr.z;  // Unsigned higher
      cond_ls: o_cond_pass = !psr.c || psr.z;
      cond_ge: o_cond_pass = (psr.n == psr.v);
      cond_lt: o_cond_pass = (psr.n != psr.v);
      cond_gt: o_cond_pass = !psr.z && (psr.n == psr.v);
      cond_le: o_cond_pass = psr.z || (psr.n != psr.v);
      cond_al: o_cond_pass = 1'b1;
      default: o_cond_pass = 1'b0;             // NV
    endcase
  end

endmodule

`default_nettype wire

// File: exu_out_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "exu_settings.svh"

module exu_out_port (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  logic [`EXU_DATA_W-1:0]  i_result,
  input  exu_pkg::flags_t         i_new_flags,
  input  logic                    i_cond_pass,
  input  logic                    i_res_credit,
  output logic                    o_flag_update,
  output logic                    o_res_valid,
  output logic                    o_res_write,
  output logic [`EXU_REG_W-1:0]   o_res_rd,
  output logic [`EXU_DATA_W-1:0]  o_res_data,
  output exu_pkg::flags_t         o_res_flags,
  exu_op_if.exec                  op
);
  import exu_pkg::*;

  localparam int CNT_W = $clog2(`EXU_OUT_CREDITS + 1);

  logic [CNT_W-1:0] credit_cnt;
  logic             active;

  // The only place where an operation is taken
  assign op.take = op.valid && (credit_cnt != '0);

  assign active        = i_cond_pass && (op.alu_op != alu_nop);
  assign o_flag_update = op.take && active && op.set_flags;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      credit_cnt  <= CNT_W'(`EXU_OUT_CREDITS);
      o_res_valid <= 1'b0;
    end else begin
      if (op.take && !i_res_credit) begin
        credit_cnt <= credit_cnt - 1'b1;
      end else if (!op.take && i_res_credit) begin
        credit_cnt <= credit_cnt + 1'b1;
      end
      o_res_valid <= op.take;
    end
  end

  always_ff @(posedge clk) begin
    if (op.take) begin
      o_res_write <= active;
      o_res_rd    <= op.rd;
      o_res_data  <= i_result;
      o_res_flags <= i_new_flags; // Flags as they stand after this instruction
    end
  end

endmodule

`default_nettype wire

// File: exu_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "exu_settings.svh"

module exu_top (
  input  logic                    clk,
  input  logic                    i_rst_n,
  input  logic                    i_valid,
  input  logic [31:0]             i_instr,
  input  logic [`EXU_DATA_W-1:0]  i_rn_val,
  input  logic [`EXU_DATA_W-1:0]  i_rm_val,
  input  logic                    i_res_credit,
  output logic                    o_credit_return,
  output logic                    o_res_valid,
  output logic                    o_res_write,
  output logic [`EXU_REG_W-1:0]   o_res_rd,
  output logic [`EXU_DATA_W-1:0]  o_res_data,
  output logic [3:0]              o_res_flags
);
  import exu_pkg::*;

  exu_req_t               in_req;
  exu_req_t               q_req;
  logic                   q_valid;
  logic                   pop;
  logic [`EXU_DATA_W-1:0] alu_result;
  flags_t                 alu_flags;
  flags_t                 psr_flags;
  flags_t                 flags_after;
  logic                   carry;
  logic                   cond_pass;
  logic                   flag_update;

  exu_op_if op_bus ();

  assign in_req = '{instr: i_instr, rn_val: i_rn_val, rm_val: i_rm_val};

  // Held flags pass through unless this operation sets them
  assign flags_after = flag_update ? alu_flags : psr_flags;

  exu_in_queue u_queue (
    .clk(clk), .i_rst_n(i_rst_n), .i_valid(i_valid), .i_req(in_req), .i_pop(pop),
    .o_req(q_req), .o_req_valid(q_valid), .o_credit_return(o_credit_return)
  );

  exu_decode u_decode (
    .clk(clk), .i_rst_n(i_rst_n), .i_req(q_req), .i_req_valid(q_valid),
    .o_pop(pop), .op(op_bus.stage)
  );

  exu_alu u_alu (
    .i_op(op_bus.alu_op), .i_a(op_bus.operand_a), .i_b(op_bus.operand_b),
    .i_carry(carry), .o_result(alu_result), .o_flags(alu_flags)
  );

  exu_psr_cond u_psr (
    .clk(clk), .i_rst_n(i_rst_n), .i_cond(op_bus.cond), .i_new_flags(alu_flags),
    .i_update(flag_update), .o_flags(psr_flags), .o_carry(carry), .o_cond_pass(cond_pass)
  );

  exu_out_port u_out (
    .clk(clk), .i_rst_n(i_rst_n), .i_result(alu_result), .i_new_flags(flags_after),
    .i_cond_pass(cond_pass), .i_res_credit(i_res_credit), .o_flag_update(flag_update),
    .o_res_valid(o_res_valid), .o_res_write(o_res_write), .o_res_rd(o_res_rd),
    .o_res_data(o_res_data), .o_res_flags(o_res_flags), .op(op_bus.exec)
  );

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic o_rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Released on a falling edge
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    o_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_exu.sv
`timescale 1ns/1ns
`default_nettype none

`include "exu_settings.svh"

module tb_exu;

  localparam int N_SENT = 142;
  localparam int LIMIT  = 20 * N_SENT + 8;

  logic                   clk;
  logic                   rst_n;
  logic                   i_valid;
  logic [31:0]            i_instr;
  logic [`EXU_DATA_W-1:0] i_rn_val;
  logic [`EXU_DATA_W-1:0] i_rm_val;
  logic                   i_res_credit = 1'b0;
  logic                   o_credit_return;
  logic                   o_res_valid;
  logic                   o_res_write;
  logic [`EXU_REG_W-1:0]  o_res_rd;
  logic [`EXU_DATA_W-1:0] o_res_data;
  logic [3:0]             o_res_flags;

  logic [31:0] exp_data  [256];
  logic [3:0]  exp_rd    [256];
  logic [3:0]  exp_flags [256];
  logic        exp_write [256];
  logic [3:0]  mflags    = '0;  // Model NZCV
  logic        credit_en = 1'b1;
  int          wr_idx    = 0;
  int          rd_idx    = 0;
  int          returned  = 0;
  int          out_used  = 0;   // Results seen whose credit is not yet back
  int          errors    = 0;
  int          cycles    = 0;
  integer      seed      = 32'h9abb_3e4e;

  tb_clock u_clock (.clk(clk), .o_rst_n(rst_n));

  exu_top dut (
    .clk(clk), .i_rst_n(rst_n), .i_valid(i_valid), .i_instr(i_instr),
    .i_rn_val(i_rn_val), .i_rm_val(i_rm_val), .i_res_credit(i_res_credit),
    .o_credit_return(o_credit_return), .o_res_valid(o_res_valid), .o_res_write(o_res_write),
    .o_res_rd(o_res_rd), .o_res_data(o_res_data), .o_res_flags(o_res_flags)
  );

  function automatic logic [3:0] op_of(input int i);
    return (i % 12 < 8) ? 4'(i % 12) : 4'(i % 12 + 4);
  endfunction

  function automatic logic [31:0] rot_right(input logic [31:0] v, input int amt);
    logic [63:0] t;
    t = {v, v} >> amt;
    return t[31:0];
  endfunction

  function automatic logic [31:0] operand_b(input logic [31:0] instr, input logic [31:0] rm);
    logic [63:0] t;
    int          amt;
    amt = int'(instr[11:7]);
    if (instr[25]) return rot_right({24'h0, instr[7:0]}, 2 * int'(instr[11:8]));
    if (amt == 0) return rm;
    case (instr[6:5])
      2'b00:   return rm << amt;
      2'b01:   return rm >> amt;
      2'b10: begin
        t = {{32{rm[31]}}, rm} >> amt;  // ASR
        return t[31:0];
      end
      default: return rot_right(rm, amt);
    endcase
  endfunction

  function automatic logic cond_holds(input logic [3:0] cond, input logic [3:0] f);
    logic n;
    logic z;
    logic c;
    logic v;
    {n, z, c, v} = f;
    case (cond)
      4'h0:    return z;
      4'h1:    return !z;
      4'h2:    return c;
      4'h3:    return !c;
      4'h4:    return n;
      4'h5:    return !n;
      4'h6:    return v;
      4'h7:    return !v;
      4'h8:    return c && !z;
      4'h9:    return !c || z;
      4'ha:    return n == v;
      4'hb:    return n != v;
      4'hc:    return !z && (n == v);
      4'hd:    return z || (n != v);
      4'he:    return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // C is carry out, or no borrow for subtraction
  task automatic alu_ref(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b,
                         input logic cin, output logic [31:0] r, output logic [3:0] f);
    logic [31:0] x;
    logic [31:0] y;
    logic        sub;
    logic        arith;
    longint      k;
    longint      us;
    longint      ss;
    sub   = op inside {4'h2, 4'h3, 4'h6, 4'h7};
    arith = op inside {[4'h2:4'h7]};
    k     = (op == 4'h5) ? longint'(cin) : (op inside {4'h6, 4'h7}) ? longint'(!cin) : 0;
    x     = (op inside {4'h3, 4'h7}) ? b : a;  // Reverse forms
    y     = (op inside {4'h3, 4'h7}) ? a : b;
    us = sub ? longint'(x) - longint'(y) - k : longint'(x) + longint'(y) + k;
    ss = sub ? longint'($signed(x)) - longint'($signed(y)) - k
             : longint'($signed(x)) + longint'($signed(y)) + k;
    case (op)
      4'h0:    r = a & b;
      4'h1:    r = a ^ b;
      4'hc:    r = a | b;
      4'hd:    r = b;
      4'he:    r = a & ~b;
      4'hf:    r = ~b;
      default: r = us[31:0];
    endcase
    f[3] = r[31];
    f[2] = (r == 32'h0);
    f[1] = arith && (sub ? (us >= 0) : us[32]);
    f[0] = arith && (ss != longint'($signed(r)));
  endtask

  task automatic send(input logic [31:0] instr, input logic [31:0] rn, input logic [31:0] rm);
    logic [31:0] r;
    logic [3:0]  f;
    logic        dp;
    logic        pass;
    dp = (instr[27:26] == 2'b00) && !(instr[24:21] inside {[4'h8:4'hb]}) &&
         (instr != 32'h0) && (instr[25] || !instr[4]);
    pass = cond_holds(instr[31:28], mflags);
    alu_ref(instr[24:21], rn, operand_b(instr, rm), mflags[1], r, f);
    exp_write[wr_idx] = dp && pass;
    exp_rd[wr_idx]    = instr[15:12];
    exp_data[wr_idx]  = r;
    if (dp && pass && instr[20]) mflags = f;
    exp_flags[wr_idx] = mflags;
    while (wr_idx - returned >= `EXU_QUEUE_DEPTH) @(negedge clk);
    i_valid  = 1'b1;
    i_instr  = instr;
    i_rn_val = rn;
    i_rm_val = rm;
    wr_idx++;
    @(negedge clk);
    i_valid = 1'b0;
  endtask

  task automatic drain();
    while (rd_idx != wr_idx || out_used != 0) @(negedge clk);
    repeat (4) @(negedge clk);
  endtask

  task automatic end_run(input logic timed_out);
    $display("Results checked: %0d, errors: %0d", rd_idx, errors);
    if (errors == 0 && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  // Output credits come back on two cycles of three
  always @(negedge clk) begin
    i_res_credit = credit_en && (out_used > 0) && (cycles % 3 != 0);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (rst_n) begin
      if (o_res_valid) rd_idx <= rd_idx + 1;
      if (o_credit_return) returned <= returned + 1;
      out_used <= out_used + int'(o_res_valid) - int'(i_res_credit);
    end
    if (cycles >= LIMIT) begin
      $display("Timeout: the run did not end within %0d cycles", LIMIT);
      end_run(1'b1);
    end
  end

  a_known: assert property (@(negedge clk) disable iff (!rst_n) o_res_valid |-> rd_idx < wr_idx)
    else begin
      errors = errors + 1;
      $display("ERR %0t: result beat with no request outstanding", $time);
    end

  a_write: assert property (@(negedge clk) disable iff (!rst_n)
      o_res_valid |-> o_res_write == exp_write[rd_idx])
    else begin
      errors = errors + 1;
      $display("ERR %0t: result %0d write %b, expected %b", $time, rd_idx, o_res_write,
               exp_write[rd_idx]);
    end

  a_flags: assert property (@(negedge clk) disable iff (!rst_n)
      o_res_valid |-> o_res_flags == exp_flags[rd_idx])
    else begin
      errors = errors + 1;
      $display("ERR %0t: result %0d flags %b, expected %b", $time, rd_idx, o_res_flags,
               exp_flags[rd_idx]);
    end

  a_data: assert property (@(negedge clk) disable iff (!rst_n)
      o_res_valid && exp_write[rd_idx] |->
        o_res_data == exp_data[rd_idx] && o_res_rd == exp_rd[rd_idx])
    else begin
      errors = errors + 1;
      $display("ERR %0t: result %0d r%0d=%h, expected r%0d=%h", $time, rd_idx, o_res_rd,
               o_res_data, exp_rd[rd_idx], exp_data[rd_idx]);
    end

  a_credit: assert property (@(negedge clk) disable iff (!rst_n)
      o_res_valid |-> out_used < `EXU_OUT_CREDITS)
    else begin
      errors = errors + 1;
      $display("ERR %0t: result sent with no output credit left", $time);
    end

  initial begin : stimulus
    logic [31:0] r;
    logic [11:0] op2;
    int          base;
    i_valid  = 1'b0;
    i_instr  = '0;
    i_rn_val = '0;
    i_rm_val = '0;
    @(posedge rst_n);
    @(negedge clk);
    // All twelve operations, zero shift amount on every fourth
    for (int i = 0; i < 48; i++) begin
      r   = $random(seed);
      if (i % 4 == 0) r[0] = 1'b0; // Register operand
      op2 = r[31:20];
      if (!r[0]) begin
        op2[4]   = 1'b0;
        op2[6:5] = 2'(i / 4);
        if (i % 4 == 0) op2[11:7] = '0;
      end
      send({4'he, 2'b00, r[0], op_of(i), r[1], 4'h1, r[5:2], op2}, $random(seed), $random(seed));
    end
    // Every condition code, SUBS of equal values sets Z now and then
    for (int i = 0; i < 64; i++) begin
      r = $random(seed);
      if (i % 5 == 0) begin
        send({4'he, 3'b000, 4'h2, 1'b1, 4'h1, 4'h2, 12'h000}, r, r);
      end else begin
        send({4'(i), 3'b000, op_of(i + 3), r[1], 4'h1, r[5:2], r[31:25], 1'b0, 4'h3},
             $random(seed), $random(seed));
      end
    end
    // ADDS leaves C for the following ADC, SBC or RSC
    for (int i = 0; i < 8; i++) begin
      send({4'he, 3'b000, 4'h4, 1'b1, 4'h1, 4'h4, 12'h000}, $random(seed), $random(seed));
      send({4'he, 3'b000, 4'h5 + 4'(i % 3), 1'b0, 4'h1, 4'h5, 12'h000},
           $random(seed), $random(seed));
    end
    // Unsupported encodings
    send(32'h0000_0000, 32'h1, 32'h2);
    for (int i = 8; i < 12; i++) begin
      send({4'he, 3'b000, 4'(i), 1'b1, 4'h1, 4'h6, 12'h000}, $random(seed), $random(seed));
    end
    send({4'he, 3'b000, 4'h4, 1'b1, 4'h1, 4'h7, 12'h012}, $random(seed), $random(seed));
    send(32'he591_2004, $random(seed), $random(seed)); // LDR
    send(32'hea00_0010, $random(seed), $random(seed)); // B
    drain();
    credit_en = 1'b0;
    base      = rd_idx;
    for (int i = 0; i < 6; i++) begin
      send({4'he, 3'b001, 4'hd, 1'b0, 4'h0, 4'(i), 4'h0, 8'(i)}, '0, '0);
    end
    repeat (20) @(negedge clk);
    assert (rd_idx - base == `EXU_OUT_CREDITS)
      else begin
        errors = errors + 1;
        $display("ERR %0t: %0d results without credit, expected %0d", $time, rd_idx - base,
                 `EXU_OUT_CREDITS);
      end
    credit_en = 1'b1;
    drain();
    assert (returned == wr_idx)
      else begin
        errors = errors + 1;
        $display("ERR %0t: %0d credit returns for %0d requests", $time, returned, wr_idx);
      end
    end_run(1'b0);
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
exu_pkg.sv
exu_op_if.sv
exu_in_queue.sv
exu_decode.sv
exu_alu.sv
exu_psr_cond.sv
exu_out_port.sv
exu_top.sv
tb_clock.sv
tb_exu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_exu -f project.f -o sim_exu
out=$(./obj_dir/sim_exu)
echo "$out"
echo "$out" | grep -qx "Finished with no errors"
